/* soc_settings.svh */
// peripheral SoC settings
// address map nibbles, fixed readback words and UART divider reset value
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// top address nibble of each mapped 256 MB region
`define SOC_REGION_UART 4'h1
`define SOC_REGION_CTRL 4'h2

// read at control offset 0
`define SOC_VERSION 32'h0000_0100

// read data for an access to an unmapped region
`define SOC_BUS_ERR_WORD 32'hdead_beef

// close to 115200 baud at 48 MHz, each bit lasts div+1 cycles
`define SOC_UART_DIV_RESET 32'd415

`endif

/* soc_bus_pkg.sv */
// bus types
// request and response of the single-master valid/ready bus
`default_nettype none

package soc_bus_pkg;

	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// all zero means a read
	typedef logic [3:0] bus_strb_t;

	// held by the master from valid until ready
	typedef struct packed {
		logic      valid;
		bus_addr_t addr;
		bus_data_t wdata;
		bus_strb_t wstrb;
	} bus_req_t;

	// ready lasts one cycle, rdata valid in that cycle
	typedef struct packed {
		logic      ready;
		bus_data_t rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

/* soc_map_pkg.sv */
// address map types
// regions, register word offsets and the PSRAM pin bundle
`default_nettype none

package soc_map_pkg;

	typedef enum logic [1:0] {
		region_uart,
		region_ctrl,
		region_none
	} soc_region_t;

	// word offset, address bits 4 to 2
	typedef logic [2:0] reg_off_t;

	// same bit order as the override register bits 6 to 0
	typedef struct packed {
		logic       oe;
		logic       sclk;
		logic       nce;
		logic [3:0] sout;
	} psram_pins_t;

endpackage

`default_nettype wire

/* soc_bus_decode.sv */
// bus decoder
// picks a target by the top address nibble, muxes read data, merges ready
// and flags accesses to unmapped regions with a one-cycle interrupt
`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module soc_bus_decode (
	input  logic                  clk48m,
	input  logic                  rst,
	input  soc_bus_pkg::bus_req_t bus_req,
	output soc_bus_pkg::bus_rsp_t bus_rsp,
	output logic                  ctrl_sel,
	output logic                  uart_sel,
	input  soc_bus_pkg::bus_data_t ctrl_rdata,
	input  soc_bus_pkg::bus_data_t uart_rdata,
	input  logic                  uart_ready,
	output logic                  irq_bus_err
);

	soc_map_pkg::soc_region_t region;
	logic bus_err;

	// region from the top nibble
	always_comb begin
		case (bus_req.addr[31:28])
			`SOC_REGION_UART: begin
				region = soc_map_pkg::region_uart;
			end
			`SOC_REGION_CTRL: begin
				region = soc_map_pkg::region_ctrl;
			end
			default: begin
				region = soc_map_pkg::region_none;
			end
		endcase
	end

	assign ctrl_sel = bus_req.valid && (region == soc_map_pkg::region_ctrl);
	assign uart_sel = bus_req.valid && (region == soc_map_pkg::region_uart);
	assign bus_err  = bus_req.valid && (region == soc_map_pkg::region_none);

	// read data follows the decoded region
	always_comb begin
		case (region)
			soc_map_pkg::region_uart: begin
				bus_rsp.rdata = uart_rdata;
			end
			soc_map_pkg::region_ctrl: begin
				bus_rsp.rdata = ctrl_rdata;
			end
			default: begin
				bus_rsp.rdata = `SOC_BUS_ERR_WORD;
			end
		endcase
	end

	// register block answers at once, unmapped too
	// uart may hold a data write while tx is busy
	assign bus_rsp.ready = ctrl_sel || (uart_sel && uart_ready) || bus_err;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			irq_bus_err <= 1'b0;
		end else begin
			irq_bus_err <= bus_err;
		end
	end

endmodule

`default_nettype wire

/* soc_ctrl_regs.sv */
// control register block
// LEDs, version word, PSRAM pin override and the second CPU run bit
`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module soc_ctrl_regs (
	input  logic                     clk48m,
	input  logic                     rst,
	input  logic                     sel,
	input  soc_map_pkg::reg_off_t    off,
	input  soc_bus_pkg::bus_data_t   wdata,
	input  soc_bus_pkg::bus_strb_t   wstrb,
	output soc_bus_pkg::bus_data_t   rdata,
	output logic [5:0]               led,
	output logic [1:0]               cpu_run,
	input  soc_map_pkg::psram_pins_t qpi_pins,
	output soc_map_pkg::psram_pins_t psram_pins
);

	logic [7:0] ovr;
	logic       run1;
	logic       wr;

	assign wr = sel && wstrb[0];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led  <= 6'd0;
			ovr  <= 8'd0;
			run1 <= 1'b0;
		end else if (wr) begin
			case (off)
				3'd0: begin
					led <= wdata[5:0];
				end
				3'd1: begin
					ovr <= wdata[7:0];
				end
				3'd3: begin
					run1 <= wdata[1];
				end
				default: begin
				end
			endcase
		end
	end

	// first CPU always runs
	assign cpu_run = {run1, 1'b1};

	always_comb begin
		case (off)
			3'd0: begin
				rdata = `SOC_VERSION;
			end
			3'd1: begin
				rdata = {24'd0, ovr};
			end
			3'd2: begin
				rdata = {26'd0, led};
			end
			default: begin
				rdata = '0;
			end
		endcase
	end

	// bit 7 hands the pins to the override value
	always_ff @(posedge clk48m) begin
		if (ovr[7]) begin
			psram_pins <= soc_map_pkg::psram_pins_t'(ovr[6:0]);
		end else begin
			psram_pins <= qpi_pins;
		end
	end

endmodule

`default_nettype wire

/* soc_uart.sv */
// simple UART
// 8N1 transmitter and receiver, divider register and one-byte rx buffer
// offset bit 0 selects data (0) or divider (1)
`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module soc_uart (
	input  logic                   clk48m,
	input  logic                   rst,
	input  logic                   sel,
	input  soc_map_pkg::reg_off_t  off,
	input  soc_bus_pkg::bus_data_t wdata,
	input  soc_bus_pkg::bus_strb_t wstrb,
	output soc_bus_pkg::bus_data_t rdata,
	output logic                   ready,
	output logic                   tx,
	input  logic                   rx
);

	typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_t;
	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	soc_bus_pkg::bus_data_t div;
	soc_bus_pkg::bus_data_t tx_cnt;
	soc_bus_pkg::bus_data_t rx_cnt;
	tx_state_t  tx_state;
	rx_state_t  rx_state;
	logic [7:0] tx_shift;
	logic [2:0] tx_bit;
	logic [7:0] rx_shift;
	logic [2:0] rx_bit;
	logic [7:0] rx_buf;
	logic       rx_full;
	logic       rx_meta;
	logic       rx_sync;
	logic       tx_busy;
	logic       dat_wr;
	logic       dat_rd;
	logic       div_wr;

	assign tx_busy = (tx_state != tx_idle);
	assign dat_wr  = sel && !off[0] && wstrb[0];
	assign dat_rd  = sel && !off[0] && (wstrb == '0);
	assign div_wr  = sel && off[0];

	// only a data write waits for the transmitter
	assign ready = sel && !(dat_wr && tx_busy);

	always_comb begin
		if (off[0]) begin
			rdata = div;
		end else if (rx_full) begin
			rdata = {24'd0, rx_buf};
		end else begin
			rdata = '1;
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			div <= `SOC_UART_DIV_RESET;
		end else if (div_wr) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					div[8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// transmitter, lsb first
	always_ff @(posedge clk48m) begin
		if (rst) begin
			tx_state <= tx_idle;
			tx_cnt   <= '0;
			tx_bit   <= 3'd0;
			tx       <= 1'b1;
		end else begin
			tx_cnt <= tx_cnt + 1'b1;
			case (tx_state)
				tx_idle: begin
					if (dat_wr) begin
						tx_shift <= wdata[7:0];
						tx_cnt   <= '0;
						tx       <= 1'b0;
						tx_state <= tx_start;
					end
				end
				tx_start: begin
					if (tx_cnt == div) begin
						tx_cnt   <= '0;
						tx_bit   <= 3'd0;
						tx       <= tx_shift[0];
						tx_shift <= tx_shift >> 1;
						tx_state <= tx_data;
					end
				end
				tx_data: begin
					if (tx_cnt == div) begin
						tx_cnt <= '0;
						if (tx_bit == 3'd7) begin
							tx       <= 1'b1;
							tx_state <= tx_stop;
						end else begin
							tx       <= tx_shift[0];
							tx_shift <= tx_shift >> 1;
							tx_bit   <= tx_bit + 1'b1;
						end
					end
				end
				default: begin
					if (tx_cnt == div) begin
						tx_state <= tx_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// receiver samples mid-bit, start bit checked at half period
	always_ff @(posedge clk48m) begin
		if (rst) begin
			rx_state <= rx_idle;
			rx_cnt   <= '0;
			rx_bit   <= 3'd0;
			rx_full  <= 1'b0;
		end else begin
			rx_cnt <= rx_cnt + 1'b1;
			if (dat_rd) begin
				rx_full <= 1'b0;
			end
			case (rx_state)
				rx_idle: begin
					rx_cnt <= '0;
					if (!rx_sync) begin
						rx_state <= rx_start;
					end
				end
				rx_start: begin
					if (rx_cnt == (div >> 1)) begin
						rx_cnt   <= '0;
						rx_bit   <= 3'd0;
						rx_state <= rx_sync ? rx_idle : rx_data;
					end
				end
				rx_data: begin
					if (rx_cnt == div) begin
						rx_cnt   <= '0;
						rx_shift <= {rx_sync, rx_shift[7:1]};
						rx_bit   <= rx_bit + 1'b1;
						if (rx_bit == 3'd7) begin
							rx_state <= rx_stop;
						end
					end
				end
				default: begin
					if (rx_cnt == div) begin
						// framing error drops the byte
						if (rx_sync) begin
							rx_buf  <= rx_shift;
							rx_full <= 1'b1;
						end
						rx_state <= rx_idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* soc_periph_top.sv */
// peripheral top level
// bus decoder, control registers and UART behind one bus master port
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top (
	input  logic                     clk48m,
	input  logic                     rst,
	input  soc_bus_pkg::bus_req_t    bus_req,
	output soc_bus_pkg::bus_rsp_t    bus_rsp,
	output logic                     irq_bus_err,
	output logic [5:0]               led,
	output logic [1:0]               cpu_run,
	output logic                     uart_tx,
	input  logic                     uart_rx,
	input  soc_map_pkg::psram_pins_t qpi_pins,
	output soc_map_pkg::psram_pins_t psram_pins
);

	logic                   ctrl_sel;
	logic                   uart_sel;
	logic                   uart_ready;
	soc_bus_pkg::bus_data_t ctrl_rdata;
	soc_bus_pkg::bus_data_t uart_rdata;

	soc_bus_decode u_decode (
		.clk48m      (clk48m),
		.rst         (rst),
		.bus_req     (bus_req),
		.bus_rsp     (bus_rsp),
		.ctrl_sel    (ctrl_sel),
		.uart_sel    (uart_sel),
		.ctrl_rdata  (ctrl_rdata),
		.uart_rdata  (uart_rdata),
		.uart_ready  (uart_ready),
		.irq_bus_err (irq_bus_err)
	);

	soc_ctrl_regs u_ctrl (
		.clk48m     (clk48m),
		.rst        (rst),
		.sel        (ctrl_sel),
		.off        (bus_req.addr[4:2]),
		.wdata      (bus_req.wdata),
		.wstrb      (bus_req.wstrb),
		.rdata      (ctrl_rdata),
		.led        (led),
		.cpu_run    (cpu_run),
		.qpi_pins   (qpi_pins),
		.psram_pins (psram_pins)
	);

	soc_uart u_uart (
		.clk48m (clk48m),
		.rst    (rst),
		.sel    (uart_sel),
		.off    (bus_req.addr[4:2]),
		.wdata  (bus_req.wdata),
		.wstrb  (bus_req.wstrb),
		.rdata  (uart_rdata),
		.ready  (uart_ready),
		.tx     (uart_tx),
		.rx     (uart_rx)
	);

endmodule

`default_nettype wire

/* tb_soc_periph.sv */
// testbench for the peripheral top level
// bus master tasks, UART line model and assertion checks
`timescale 1ns/1ps
`default_nettype none
`include "soc_settings.svh"

module tb_soc_periph;

	// six frames at test_div need under 1000 cycles
	localparam int cycle_limit = 20000;
	localparam int test_div = 15;
	localparam int bit_cycles = test_div + 1;
	localparam logic [31:0] ctrl_base = {`SOC_REGION_CTRL, 28'd0};
	localparam logic [31:0] uart_base = {`SOC_REGION_UART, 28'd0};

	logic                     clk48m;
	logic                     rst;
	soc_bus_pkg::bus_req_t    bus_req;
	soc_bus_pkg::bus_rsp_t    bus_rsp;
	logic                     irq_bus_err;
	logic [5:0]               led;
	logic [1:0]               cpu_run;
	logic                     uart_tx;
	logic                     uart_rx;
	soc_map_pkg::psram_pins_t qpi_pins;
	soc_map_pkg::psram_pins_t psram_pins;
	logic                     unmapped_req;
	string                    test_name = "reset";
	int                       errors = 0;
	int                       test_errors = 0;
	int                       tests_failed = 0;
	int                       cycles = 0;

	soc_periph_top dut (.*);

	initial begin
		clk48m = 1'b0;
		forever #50 clk48m = ~clk48m;
	end

	always @(posedge clk48m) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	assign unmapped_req = bus_req.valid && (bus_req.addr[31:28] != `SOC_REGION_UART)
		&& (bus_req.addr[31:28] != `SOC_REGION_CTRL);

	// interrupt one cycle after each unmapped access
	irq_follows_err: assert property (@(posedge clk48m) disable iff (rst)
		irq_bus_err == $past(unmapped_req))
	else begin
		$display("ERR %s irq_bus_err expected %b actual %b", test_name, !irq_bus_err,
			irq_bus_err);
		errors++;
	end

	first_cpu_runs: assert property (@(posedge clk48m) disable iff (rst) cpu_run[0])
	else begin
		$display("ERR %s cpu_run[0] expected 1 actual 0", test_name);
		errors++;
	end

	task automatic check_word(input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERR %s expected %h actual %h", test_name, exp, act);
			errors++;
		end
	endtask

	// holds valid until ready, returns 5 ns past the completing edge
	task automatic transfer(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output logic [31:0] rdata, output int waits);
		waits = 0;
		bus_req.valid = 1'b1;
		bus_req.addr = addr;
		bus_req.wdata = wdata;
		bus_req.wstrb = wstrb;
		@(negedge clk48m);
		while (!bus_rsp.ready) begin
			waits++;
			@(negedge clk48m);
		end
		rdata = bus_rsp.rdata;
		@(posedge clk48m);
		#5;
		bus_req = '0;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb);
		logic [31:0] rdata;
		int waits;
		transfer(addr, wdata, wstrb, rdata, waits);
	endtask

	task automatic read_word(input logic [31:0] addr, output logic [31:0] rdata);
		int waits;
		transfer(addr, 32'd0, 4'h0, rdata, waits);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk48m);
		#5;
	endtask

	// start bit began at the last edge, each bit sampled in its middle
	task automatic check_tx_frame(input logic [7:0] data);
		logic [9:0] seen;
		for (int k = 0; k < 10; k++) begin
			repeat (k == 0 ? bit_cycles / 2 + 1 : bit_cycles) @(negedge clk48m);
			seen[k] = uart_tx;
		end
		check_word({22'd0, 1'b1, data, 1'b0}, {22'd0, seen});
		// back to the drive point after the edge
		@(posedge clk48m);
		#5;
	endtask

	task automatic send_rx_frame(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int k = 0; k < 10; k++) begin
			uart_rx = frame[k];
			wait_cycles(bit_cycles);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		if (errors == test_errors) begin
			$display("%s: ok", test_name);
		end else begin
			$display("%s: %0d errors", test_name, errors - test_errors);
			tests_failed++;
		end
	endtask

	initial begin
		logic [31:0] rdata;
		logic [31:0] rnd;
		logic [7:0]  byte0;
		logic [7:0]  byte1;
		int          waits;
		rnd = $urandom(32'h03799a2c);
		rst = 1'b1;
		bus_req = '0;
		uart_rx = 1'b1;
		qpi_pins = '0;
		repeat (8) @(posedge clk48m);
		#5;
		rst = 1'b0;

		begin_test("version_led");
		check_word(32'd0, {26'd0, led});
		read_word(ctrl_base, rdata);
		check_word(`SOC_VERSION, rdata);
		repeat (4) begin
			rnd = $urandom;
			write_word(ctrl_base, rnd, 4'h1);
			check_word({26'd0, rnd[5:0]}, {26'd0, led});
			read_word(ctrl_base + 8, rdata);
			check_word({26'd0, rnd[5:0]}, rdata);
		end
		end_test();

		begin_test("psram_override");
		rnd = $urandom;
		write_word(ctrl_base + 4, {24'd0, 1'b1, rnd[6:0]}, 4'h1);
		byte0 = {1'b0, rnd[6:0]};
		repeat (4) begin
			rnd = $urandom;
			qpi_pins = rnd[6:0];
			wait_cycles(1);
			check_word({24'd0, byte0}, {25'd0, psram_pins});
		end
		write_word(ctrl_base + 4, 32'd0, 4'h1);
		wait_cycles(1);
		repeat (4) begin
			rnd = $urandom;
			qpi_pins = rnd[6:0];
			wait_cycles(1);
			check_word({25'd0, rnd[6:0]}, {25'd0, psram_pins});
		end
		end_test();

		begin_test("cpu_run");
		check_word(32'd1, {30'd0, cpu_run});
		write_word(ctrl_base + 12, 32'h2, 4'h1);
		check_word(32'd3, {30'd0, cpu_run});
		write_word(ctrl_base + 12, 32'h0, 4'h1);
		check_word(32'd1, {30'd0, cpu_run});
		end_test();

		begin_test("bus_error");
		repeat (3) begin
			rnd = $urandom;
			while (rnd[31:28] == `SOC_REGION_UART || rnd[31:28] == `SOC_REGION_CTRL) begin
				rnd = $urandom;
			end
			transfer(rnd, 32'd0, 4'h0, rdata, waits);
			check_word(`SOC_BUS_ERR_WORD, rdata);
			check_word(32'd0, waits);
			check_word(32'd1, {31'd0, irq_bus_err});
			wait_cycles(1);
			check_word(32'd0, {31'd0, irq_bus_err});
		end
		end_test();

		begin_test("uart_tx");
		// idle line is high
		check_word(32'd1, {31'd0, uart_tx});
		read_word(uart_base + 4, rdata);
		check_word(`SOC_UART_DIV_RESET, rdata);
		write_word(uart_base + 4, test_div, 4'hf);
		read_word(uart_base + 4, rdata);
		check_word(test_div, rdata);
		rnd = $urandom;
		byte0 = rnd[7:0];
		byte1 = rnd[15:8];
		write_word(uart_base, {24'd0, byte0}, 4'h1);
		fork
			check_tx_frame(byte0);
			transfer(uart_base, {24'd0, byte1}, 4'h1, rdata, waits);
		join
		// held for the whole first frame
		check_word(10 * bit_cycles, waits);
		check_tx_frame(byte1);
		end_test();

		begin_test("uart_rx");
		rnd = $urandom;
		send_rx_frame(rnd[7:0]);
		read_word(uart_base, rdata);
		check_word({24'd0, rnd[7:0]}, rdata);
		read_word(uart_base, rdata);
		check_word(32'hffff_ffff, rdata);
		end_test();

		$display("tests 6, failed %0d, errors %0d", tests_failed, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
soc_bus_pkg.sv
soc_map_pkg.sv
soc_bus_decode.sv
soc_ctrl_regs.sv
soc_uart.sv
soc_periph_top.sv
tb_soc_periph.sv

/* Makefile */
# Verilator build and run of the peripheral testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) soc_settings.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(BUILD_DIR)
